//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_top
FILELIST := build.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP) and judge the run from $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -q "all tests passed" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
source/subsys_pkg.sv
source/copy_read_master.sv
source/copy_write_master.sv
source/pio_input_sync.sv
source/pio_edge_lane.sv
source/irq_collector.sv
source/nios_base_subsys.sv
dv/mm_slave_model.sv
dv/tb_top.sv

//--- dv/mm_slave_model.sv
`timescale 1ns/1ns
`default_nettype none

module mm_slave_model
	import subsys_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] seed,
	input  logic        heavy,
	input  addr_t       rd_address,
	input  logic        rd_read,
	output logic        rd_waitrequest,
	output data_t       rd_readdata,
	output logic        rd_readdatavalid,
	input  addr_t       wr_address,
	input  logic        wr_write,
	input  data_t       wr_writedata,
	output logic        wr_waitrequest
);

	data_t       mem [0:1023];
	logic [31:0] rng;
	logic        rd_wait_q = 1'b0;
	logic        wr_wait_q = 1'b0;
	logic        valid_q = 1'b0;
	data_t       data_q = '0;
	logic        rd_accept;
	logic        wr_accept;
	addr_t       pend_addr;
	logic [2:0]  pend_cnt = 3'd0;

	assign rd_waitrequest = rd_wait_q;
	assign wr_waitrequest = wr_wait_q;
	assign rd_readdatavalid = valid_q;
	assign rd_readdata = data_q;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// heavy mode stalls 7 of 8 cycles, light mode 1 of 4
	function automatic logic stall(input logic [31:0] r, input logic h);
		if (h)
			return r[18:16] != 3'd0;
		return r[17:16] == 2'd0;
	endfunction

	always @(posedge clk)
	begin
		// acceptance uses the values the DUT saw at this edge
		rd_accept = rd_read && !rd_wait_q;
		wr_accept = wr_write && !wr_wait_q;
		if (rst)
		begin
			rng = seed;
			for (int i = 0; i < 1024; i++)
			begin
				rng = lcg_next(rng);
				mem[10'(i)] = rng ^ 32'(i);
			end
			pend_cnt = 3'd0;
		end
		else
		begin
			if (wr_accept)
				mem[wr_address[9:0]] = wr_writedata;
			// one read in flight, latency 1 to 4 cycles from acceptance
			if (rd_accept)
			begin
				rng = lcg_next(rng);
				pend_addr = rd_address;
				pend_cnt = 3'd1 + {1'b0, rng[17:16]};
			end
		end
		#1;
		valid_q = 1'b0;
		if (pend_cnt != 3'd0)
		begin
			pend_cnt = pend_cnt - 3'd1;
			if (pend_cnt == 3'd0)
			begin
				valid_q = 1'b1;
				data_q = mem[pend_addr[9:0]];
			end
		end
		rng = lcg_next(rng);
		rd_wait_q = stall(rng, heavy);
		rng = lcg_next(rng);
		wr_wait_q = stall(rng, heavy);
	end

endmodule

`default_nettype wire

//--- dv/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top
	import subsys_pkg::*;
();

	logic        clk = 1'b0;
	logic        rst;
	logic        start;
	addr_t       src;
	addr_t       dst;
	len_t        len;
	logic        busy;
	logic        done_clear;
	addr_t       rd_address;
	logic        rd_read;
	logic        rd_waitrequest;
	data_t       rd_readdata;
	logic        rd_readdatavalid;
	addr_t       wr_address;
	logic        wr_write;
	data_t       wr_writedata;
	logic        wr_waitrequest;
	pio_t        ext_ctrl_in;
	pio_t        capture;
	pio_t        capture_clear;
	pio_t        irq_mask;
	logic        irq;
	logic        heavy;
	logic [31:0] rng;
	data_t       ref_mem [0:1023];

	nios_base_subsys u_nios_base_subsys (
		.clk              (clk),
		.rst              (rst),
		.start            (start),
		.src              (src),
		.dst              (dst),
		.len              (len),
		.busy             (busy),
		.done_clear       (done_clear),
		.rd_address       (rd_address),
		.rd_read          (rd_read),
		.rd_waitrequest   (rd_waitrequest),
		.rd_readdata      (rd_readdata),
		.rd_readdatavalid (rd_readdatavalid),
		.wr_address       (wr_address),
		.wr_write         (wr_write),
		.wr_writedata     (wr_writedata),
		.wr_waitrequest   (wr_waitrequest),
		.ext_ctrl_in      (ext_ctrl_in),
		.capture          (capture),
		.capture_clear    (capture_clear),
		.irq_mask         (irq_mask),
		.irq              (irq)
	);

	mm_slave_model u_mm_slave_model (
		.clk              (clk),
		.rst              (rst),
		.seed             (32'd95392),
		.heavy            (heavy),
		.rd_address       (rd_address),
		.rd_read          (rd_read),
		.rd_waitrequest   (rd_waitrequest),
		.rd_readdata      (rd_readdata),
		.rd_readdatavalid (rd_readdatavalid),
		.wr_address       (wr_address),
		.wr_write         (wr_write),
		.wr_writedata     (wr_writedata),
		.wr_waitrequest   (wr_waitrequest)
	);

	always
	begin
		#4 clk = ~clk;
	end

	// ------------------------------
	// helpers and compare tasks
	// ------------------------------

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input data_t got, input data_t exp, input string what);
		if (got !== exp)
			report_failure($sformatf("FAIL at %0t ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_pio(input pio_t got, input pio_t exp, input string what);
		if (got !== exp)
			report_failure($sformatf("FAIL at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_failure($sformatf("FAIL at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	// inputs change and outputs are read 1 ns after each rising edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_busy_low(input string what);
		int cycles;
		cycles = 0;
		while (busy)
		begin
			if (cycles == 50000)
				report_failure($sformatf("timeout: busy never fell during %s", what));
			else
			begin
				tick();
				cycles++;
			end
		end
	endtask

	// ------------------------------
	// block copy
	// ------------------------------

	task automatic run_copy(input string what, input logic second_start);
		addr_t s;
		addr_t d;
		len_t  n;
		rng = lcg_next(rng);
		// source in words 0 to 382, destination in 512 to 894, never overlapping
		s = addr_t'(rng[23:16]);
		d = addr_t'(rng[31:24]) + addr_t'(512);
		rng = lcg_next(rng);
		n = {1'b0, rng[22:16]} + len_t'(1);
		start = 1'b1;
		src = s;
		dst = d;
		len = n;
		tick();
		start = 1'b0;
		check_bit(busy, 1'b1, "busy after start");
		if (second_start)
		begin
			// this one must be dropped, so words 900 and up stay untouched
			start = 1'b1;
			dst = addr_t'(900);
			len = len_t'(16);
			tick();
			start = 1'b0;
		end
		wait_busy_low(what);
		for (int i = 0; i < int'(n); i++)
			ref_mem[10'(d + addr_t'(i))] = ref_mem[10'(s + addr_t'(i))];

		// done flag sets one cycle after busy falls and irq one cycle later
		tick();
		check_bit(busy, 1'b0, "busy after copy end");
		check_bit(irq, 1'b0, "irq before done flag");
		tick();
		check_bit(irq, 1'b1, "irq from copy done");
		done_clear = 1'b1;
		tick();
		done_clear = 1'b0;
		check_bit(irq, 1'b1, "irq while done flag clears");
		tick();
		check_bit(irq, 1'b0, "irq after done_clear");
		repeat (4)
		begin
			tick();
			check_bit(busy, 1'b0, "busy after copy end");
		end
		for (int a = 0; a < 1024; a++)
			check_word(u_mm_slave_model.mem[10'(a)], ref_mem[10'(a)],
				$sformatf("%s, memory word %0d", what, a));
	endtask

	// ------------------------------
	// edge capture and interrupt
	// ------------------------------

	task automatic run_pio_test();
		pio_t ext_d1;
		pio_t ext_d2;
		pio_t ext_d3;
		pio_t cap_model;
		pio_t cap_next;
		logic irq_exp;
		int   hold;
		ext_d1 = '0;
		ext_d2 = '0;
		ext_d3 = '0;
		cap_model = '0;
		for (int p = 0; p < 80; p++)
		begin
			rng = lcg_next(rng);
			ext_ctrl_in = pio_t'(rng[19:16]);
			irq_mask = pio_t'(rng[23:20]);
			hold = 4 + int'(rng[25:24]);
			for (int c = 0; c < hold; c++)
			begin
				rng = lcg_next(rng);
				capture_clear = (rng[17:16] == 2'd0) ? pio_t'(rng[23:20]) : '0;
				tick();
				// an edge driven 3 cycles ago lands now and beats a clear
				irq_exp = |(cap_model & irq_mask);
				cap_next = (ext_d2 & ~ext_d3) | (cap_model & ~capture_clear);
				check_pio(capture, cap_next, "capture");
				check_bit(irq, irq_exp, "irq from masked capture");
				cap_model = cap_next;
				ext_d3 = ext_d2;
				ext_d2 = ext_d1;
				ext_d1 = ext_ctrl_in;
			end
		end
		capture_clear = '0;
	endtask

	initial
	begin
		rng = 32'd95392;
		rst = 1'b1;
		start = 1'b0;
		src = '0;
		dst = '0;
		len = '0;
		done_clear = 1'b0;
		ext_ctrl_in = '0;
		capture_clear = '0;
		irq_mask = '0;
		heavy = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		check_bit(busy, 1'b0, "busy after reset");
		check_bit(irq, 1'b0, "irq after reset");
		check_pio(capture, '0, "capture after reset");
		for (int a = 0; a < 1024; a++)
			ref_mem[10'(a)] = u_mm_slave_model.mem[10'(a)];

		for (int k = 0; k < 10; k++)
			run_copy($sformatf("random copy %0d", k), 1'b0);
		heavy = 1'b1;
		for (int k = 0; k < 3; k++)
			run_copy($sformatf("stalled copy %0d", k), 1'b0);
		heavy = 1'b0;
		run_copy("copy with a second start", 1'b1);
		run_pio_test();

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/copy_read_master.sv
`timescale 1ns/1ns
`default_nettype none

module copy_read_master
	import subsys_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  start,
	input  addr_t src,
	input  addr_t dst,
	input  len_t  len,
	output logic  busy,
	output addr_t rd_address,
	output logic  rd_read,
	input  logic  rd_waitrequest,
	input  data_t rd_readdata,
	input  logic  rd_readdatavalid,
	output logic  word_valid,
	input  logic  word_ready,
	output data_t word_data,
	output logic  wr_start,
	output addr_t wr_dst,
	output len_t  wr_len,
	input  logic  copy_done
);

	logic [1:0] state;
	logic       busy_q;
	logic       start_ok;
	logic       word_xfer;
	addr_t      addr;
	len_t       remaining;

	// a start while a copy is running is dropped
	assign start_ok = start && !busy;
	// busy already reads low in the cycle that copy_done pulses
	assign busy = busy_q && !copy_done;
	assign word_xfer = word_valid && word_ready;

	assign rd_read = (state == RD_READ);
	assign rd_address = addr;
	assign word_valid = (state == RD_HOLD);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= RD_IDLE;
			busy_q <= 1'b0;
			wr_start <= 1'b0;
		end
		else
		begin
			wr_start <= start_ok;
			if (start_ok)
				busy_q <= 1'b1;
			else if (copy_done)
				busy_q <= 1'b0;

			case (state)
				RD_IDLE:
					if (start_ok)
						state <= RD_READ;
				RD_READ:
					if (!rd_waitrequest)
						state <= RD_WAIT;
				RD_WAIT:
					if (rd_readdatavalid)
						state <= RD_HOLD;
				default:
				begin
					// the next read waits until this word has left on the stream
					if (word_xfer)
						state <= (remaining == len_t'(1)) ? RD_IDLE : RD_READ;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (start_ok)
		begin
			addr <= src;
			remaining <= len;
			wr_dst <= dst;
			wr_len <= len;
		end
		else if (word_xfer)
		begin
			addr <= addr + addr_t'(1);
			remaining <= remaining - len_t'(1);
		end
		if (state == RD_WAIT && rd_readdatavalid)
			word_data <= rd_readdata;
	end

	a_read_in_copy: assert property (@(posedge clk) disable iff (rst)
		$rose(rd_read) || $rose(word_valid) |-> busy);

	// only one read is ever outstanding, so data may arrive only while waiting
	a_no_stray_data: assert property (@(posedge clk) disable iff (rst)
		rd_readdatavalid |-> state == RD_WAIT);

endmodule

`default_nettype wire

//--- source/copy_write_master.sv
`timescale 1ns/1ns
`default_nettype none

module copy_write_master
	import subsys_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  wr_start,
	input  addr_t wr_dst,
	input  len_t  wr_len,
	input  logic  word_valid,
	output logic  word_ready,
	input  data_t word_data,
	output addr_t wr_address,
	output logic  wr_write,
	output data_t wr_writedata,
	input  logic  wr_waitrequest,
	output logic  copy_done
);

	logic [1:0] state;
	logic       wr_accept;
	addr_t      addr;
	len_t       remaining;

	assign word_ready = (state == WR_WORD);
	assign wr_write = (state == WR_WRITE);
	assign wr_address = addr;
	assign wr_accept = wr_write && !wr_waitrequest;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= WR_IDLE;
			copy_done <= 1'b0;
		end
		else
		begin
			// one cycle pulse after the write that empties the count
			copy_done <= wr_accept && (remaining == len_t'(1));
			case (state)
				WR_IDLE:
					if (wr_start)
						state <= WR_WORD;
				WR_WORD:
					if (word_valid)
						state <= WR_WRITE;
				default:
					if (wr_accept)
						state <= (remaining == len_t'(1)) ? WR_IDLE : WR_WORD;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_start)
		begin
			addr <= wr_dst;
			remaining <= wr_len;
		end
		else if (wr_accept)
		begin
			addr <= addr + addr_t'(1);
			remaining <= remaining - len_t'(1);
		end
		if (word_valid && word_ready)
			wr_writedata <= word_data;
	end

	// the slave may stall a write for many cycles and the command must not move
	a_write_held: assert property (@(posedge clk) disable iff (rst)
		wr_write && wr_waitrequest |=> $stable(wr_address) && $stable(wr_writedata));

endmodule

`default_nettype wire

//--- source/irq_collector.sv
`timescale 1ns/1ns
`default_nettype none

module irq_collector
	import subsys_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  pio_t captured,
	input  pio_t irq_mask,
	input  logic copy_done,
	input  logic done_clear,
	output logic irq
);

	logic done_flag;
	logic pio_pending;

	// only lanes enabled in the mask take part
	assign pio_pending = |(captured & irq_mask);

	// ------------------------------
	// sticky copy done flag
	// ------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
			done_flag <= 1'b0;
		else if (copy_done)
			done_flag <= 1'b1;
		else if (done_clear)
			done_flag <= 1'b0;
	end

	// ------------------------------
	// interrupt line
	// ------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
			irq <= 1'b0;
		else
			irq <= pio_pending || done_flag;
	end

	// the write master marks each finished copy with a single cycle pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		copy_done |=> !copy_done);

endmodule

`default_nettype wire

//--- source/nios_base_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module nios_base_subsys
	import subsys_pkg::*;
(
	input  logic  clk,
	input  logic  rst,

	input  logic  start,
	input  addr_t src,
	input  addr_t dst,
	input  len_t  len,
	output logic  busy,
	input  logic  done_clear,

	output addr_t rd_address,
	output logic  rd_read,
	input  logic  rd_waitrequest,
	input  data_t rd_readdata,
	input  logic  rd_readdatavalid,

	output addr_t wr_address,
	output logic  wr_write,
	output data_t wr_writedata,
	input  logic  wr_waitrequest,

	input  pio_t  ext_ctrl_in,
	output pio_t  capture,
	input  pio_t  capture_clear,
	input  pio_t  irq_mask,
	output logic  irq
);

	// stream between the two masters
	logic  word_valid;
	logic  word_ready;
	data_t word_data;

	logic  wr_start;
	addr_t wr_dst;
	len_t  wr_len;
	logic  copy_done;
	pio_t  sync_in;

	// ------------------------------
	// copy engine
	// ------------------------------

	copy_read_master u_copy_read_master (
		.clk              (clk),
		.rst              (rst),
		.start            (start),
		.src              (src),
		.dst              (dst),
		.len              (len),
		.busy             (busy),
		.rd_address       (rd_address),
		.rd_read          (rd_read),
		.rd_waitrequest   (rd_waitrequest),
		.rd_readdata      (rd_readdata),
		.rd_readdatavalid (rd_readdatavalid),
		.word_valid       (word_valid),
		.word_ready       (word_ready),
		.word_data        (word_data),
		.wr_start         (wr_start),
		.wr_dst           (wr_dst),
		.wr_len           (wr_len),
		.copy_done        (copy_done)
	);

	copy_write_master u_copy_write_master (
		.clk            (clk),
		.rst            (rst),
		.wr_start       (wr_start),
		.wr_dst         (wr_dst),
		.wr_len         (wr_len),
		.word_valid     (word_valid),
		.word_ready     (word_ready),
		.word_data      (word_data),
		.wr_address     (wr_address),
		.wr_write       (wr_write),
		.wr_writedata   (wr_writedata),
		.wr_waitrequest (wr_waitrequest),
		.copy_done      (copy_done)
	);

	// ------------------------------
	// control input and interrupt
	// ------------------------------

	pio_input_sync u_pio_input_sync (
		.clk         (clk),
		.rst         (rst),
		.ext_ctrl_in (ext_ctrl_in),
		.sync_in     (sync_in)
	);

	for (genvar i = 0; i < PIO_W; i++)
	begin : g_lane
		pio_edge_lane u_lane (
			.clk      (clk),
			.rst      (rst),
			.bit_in   (sync_in[i]),
			.clear    (capture_clear[i]),
			.captured (capture[i])
		);
	end

	irq_collector u_irq_collector (
		.clk        (clk),
		.rst        (rst),
		.captured   (capture),
		.irq_mask   (irq_mask),
		.copy_done  (copy_done),
		.done_clear (done_clear),
		.irq        (irq)
	);

endmodule

`default_nettype wire

//--- source/pio_edge_lane.sv
`timescale 1ns/1ns
`default_nettype none

module pio_edge_lane
(
	input  logic clk,
	input  logic rst,
	input  logic bit_in,
	input  logic clear,
	output logic captured
);

	logic prev;
	logic rise;

	// a 0 to 1 step against the value seen one cycle earlier
	assign rise = bit_in && !prev;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			prev <= 1'b0;
			captured <= 1'b0;
		end
		else
		begin
			prev <= bit_in;
			// a fresh edge beats a clear in the same cycle
			if (rise)
				captured <= 1'b1;
			else if (clear)
				captured <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- source/pio_input_sync.sv
`timescale 1ns/1ns
`default_nettype none

module pio_input_sync
	import subsys_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  pio_t ext_ctrl_in,
	output pio_t sync_in
);

	// ------------------------------
	// two flop synchronizer
	// ------------------------------

	// ext_ctrl_in comes from outside the clock domain
	pio_t meta;
	pio_t stable;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			meta <= '0;
			stable <= '0;
		end
		else
		begin
			meta <= ext_ctrl_in;
			stable <= meta;
		end
	end

	// every edge lane reads from this one copy
	assign sync_in = stable;

endmodule

`default_nettype wire

//--- source/subsys_pkg.sv
`default_nettype none

package subsys_pkg;

	// ------------------------------
	// widths and counts
	// ------------------------------

	// word address on both Avalon master ports
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	// copy length in words, so one copy moves 1 to 255 words
	localparam int LEN_W = 8;
	// one edge lane per external control bit
	localparam int PIO_W = 4;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [LEN_W-1:0]  len_t;
	typedef logic [PIO_W-1:0]  pio_t;

	// ------------------------------
	// FSM encodings
	// ------------------------------

	// read master walks read, wait-for-data and hold-word once per word
	localparam logic [1:0] RD_IDLE = 2'd0;
	localparam logic [1:0] RD_READ = 2'd1;
	localparam logic [1:0] RD_WAIT = 2'd2;
	localparam logic [1:0] RD_HOLD = 2'd3;

	localparam logic [1:0] WR_IDLE  = 2'd0;
	localparam logic [1:0] WR_WORD  = 2'd1;
	localparam logic [1:0] WR_WRITE = 2'd2;

endpackage

`default_nettype wire
